//--- Bender.yml
package:
  name: dm_cache

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - cpu_port.sv
      - cache_store.sv
      - cache_fill_fsm.sv
      - mem_port.sv
      - cache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_cache.sv

//--- cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// byte address seen by both buses
`define ADDR_W    16

// one data word, same width on the processor and memory side
`define DATA_W    16

// address split, msb to lsb
// tag | index | word offset | byte bit
`define TAG_W     8
`define INDEX_W   4
`define OFFSET_W  3

// direct mapped, one line per index
`define LINES     16

// words per line, filled in order from word 0
`define WORDS     8

`endif

//--- cache_fill_fsm.sv
`include "cache_defines.svh"

module cache_fill_fsm (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   miss,
    input  cache_pkg::cache_addr_u fill_addr_in,
    output logic                   fill_busy,
    output logic                   word_req,
    output cache_pkg::cache_addr_u word_addr,
    input  logic                   word_valid,
    output logic                   tag_we
);

    typedef enum logic {
        FILL_IDLE,
        FILL_BUSY
    } state_t;

    state_t                state_q;
    logic [`OFFSET_W-1:0]  count_q;
    logic                  word_req_q;
    logic [`TAG_W-1:0]     line_tag_q;
    logic [`INDEX_W-1:0]   line_index_q;
    logic                  last_word;

    // word_valid for word 7 of the line
    assign last_word = (state_q == FILL_BUSY) && word_valid
                       && (count_q == `OFFSET_W'(`WORDS - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= FILL_IDLE;
            count_q    <= '0;
            word_req_q <= 1'b0;
        end else begin
            word_req_q <= 1'b0;
            case (state_q)
                FILL_IDLE: begin
                    // first word request goes out with the rise of fill_busy
                    if (miss) begin
                        state_q    <= FILL_BUSY;
                        count_q    <= '0;
                        word_req_q <= 1'b1;
                    end
                end
                FILL_BUSY: begin
                    if (word_valid) begin
                        count_q <= count_q + 1'b1;
                        if (last_word) begin
                            state_q <= FILL_IDLE;
                        end else begin
                            word_req_q <= 1'b1;
                        end
                    end
                end
                default: state_q <= FILL_IDLE;
            endcase
        end
    end

    // line being filled, held for the whole fill
    always_ff @(posedge clk) begin
        if (miss && (state_q == FILL_IDLE)) begin
            line_tag_q   <= fill_addr_in.f.tag;
            line_index_q <= fill_addr_in.f.index;
        end
    end

    // word address of the line, byte bit always 0
    always_comb begin
        word_addr.f.tag      = line_tag_q;
        word_addr.f.index    = line_index_q;
        word_addr.f.word     = count_q;
        word_addr.f.byte_sel = 1'b0;
    end

    assign fill_busy = (state_q == FILL_BUSY);
    assign word_req  = word_req_q;
    // data and tag land in the same cycle for the last word
    assign tag_we    = last_word;

endmodule

//--- cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

    // address seen as cache fields
    // byte_sel is ignored since reads return whole words
    typedef struct packed {
        logic [`TAG_W-1:0]    tag;
        logic [`INDEX_W-1:0]  index;
        logic [`OFFSET_W-1:0] word;
        logic                 byte_sel;
    } addr_fields_t;

    // same 16 bits used as a bus address or split into tag/index/word
    typedef union packed {
        logic [`ADDR_W-1:0] raw;
        addr_fields_t       f;
    } cache_addr_u;

    // master to slave half of a read only wishbone classic bus
    // no we, no sel, no dat_o
    typedef struct packed {
        logic        cyc;
        logic        stb;
        cache_addr_u adr;
    } wb_req_t;

    // slave to master half
    // dat only meaningful while ack is high
    typedef struct packed {
        logic              ack;
        logic [`DATA_W-1:0] dat;
    } wb_rsp_t;

    // one tag array entry, one per line
    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;
    } tag_entry_t;

endpackage

//--- cache_store.sv
`include "cache_defines.svh"

module cache_store (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   lookup_valid,
    input  cache_pkg::cache_addr_u lookup_addr,
    output logic                   hit,
    output logic [`DATA_W-1:0]     rd_data,
    input  logic                   word_valid,
    input  cache_pkg::cache_addr_u word_addr,
    input  logic [`DATA_W-1:0]     word_data,
    input  logic                   tag_we
);

    // one entry per line
    cache_pkg::tag_entry_t tag_q [`LINES];

    // all words of all lines, addressed by {index, word}
    logic [`DATA_W-1:0] data_q [`LINES*`WORDS];

    logic [`INDEX_W+`OFFSET_W-1:0] rd_ptr;
    logic [`INDEX_W+`OFFSET_W-1:0] wr_ptr;
    logic                          hit_q;
    logic [`DATA_W-1:0]            rd_data_q;
    cache_pkg::tag_entry_t         rd_entry;
    logic                          first_word;

    assign rd_ptr = {lookup_addr.f.index, lookup_addr.f.word};
    assign wr_ptr = {word_addr.f.index, word_addr.f.word};

    // entry of the looked up line
    assign rd_entry = tag_q[lookup_addr.f.index];

    // word 0 starts the overwrite of a line
    assign first_word = word_valid && (word_addr.f.word == '0);

    // tag array and hit flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LINES; i++) begin
                tag_q[i] <= '0;
            end
            hit_q <= 1'b0;
        end else begin
            // line is invalid while its words are being replaced
            if (first_word) begin
                tag_q[word_addr.f.index].valid <= 1'b0;
            end
            // last word written, line now holds the new tag
            if (tag_we) begin
                tag_q[word_addr.f.index].valid <= 1'b1;
                tag_q[word_addr.f.index].tag   <= word_addr.f.tag;
            end
            if (lookup_valid) begin
                hit_q <= rd_entry.valid && (rd_entry.tag == lookup_addr.f.tag);
            end
        end
    end

    // data array
    // fill writes at {index, word}, one word per word_valid
    always_ff @(posedge clk) begin
        if (word_valid) begin
            data_q[wr_ptr] <= word_data;
        end
    end

    // word read alongside the tag compare
    // only used by the cpu port on a hit
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            rd_data_q <= data_q[rd_ptr];
        end
    end

    assign hit     = hit_q;
    assign rd_data = rd_data_q;

endmodule

//--- cache_top.sv
`include "cache_defines.svh"

module cache_top (
    input  logic               clk,
    input  logic               arst_n,
    input  cache_pkg::wb_req_t cpu_req,
    output cache_pkg::wb_rsp_t cpu_rsp,
    output cache_pkg::wb_req_t mem_req,
    input  cache_pkg::wb_rsp_t mem_rsp
);

    // lookup path, cpu port to store and back
    logic                   lookup_valid;
    cache_pkg::cache_addr_u lookup_addr;
    logic                   hit;
    logic [`DATA_W-1:0]     rd_data;

    // miss handoff
    logic                   miss;
    cache_pkg::cache_addr_u fill_addr;
    logic                   fill_busy;

    // fill path, word_addr doubles as the store write address
    logic                   word_req;
    cache_pkg::cache_addr_u word_addr;
    logic                   word_valid;
    logic [`DATA_W-1:0]     word_data;
    logic                   tag_we;

    cpu_port u_cpu_port (
        .clk          (clk),
        .arst_n       (arst_n),
        .cpu_req      (cpu_req),
        .cpu_rsp      (cpu_rsp),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr),
        .hit          (hit),
        .rd_data      (rd_data),
        .miss         (miss),
        .fill_addr_in (fill_addr),
        .fill_busy    (fill_busy)
    );

    cache_store u_cache_store (
        .clk          (clk),
        .arst_n       (arst_n),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr),
        .hit          (hit),
        .rd_data      (rd_data),
        .word_valid   (word_valid),
        .word_addr    (word_addr),
        .word_data    (word_data),
        .tag_we       (tag_we)
    );

    cache_fill_fsm u_cache_fill_fsm (
        .clk          (clk),
        .arst_n       (arst_n),
        .miss         (miss),
        .fill_addr_in (fill_addr),
        .fill_busy    (fill_busy),
        .word_req     (word_req),
        .word_addr    (word_addr),
        .word_valid   (word_valid),
        .tag_we       (tag_we)
    );

    mem_port u_mem_port (
        .clk          (clk),
        .arst_n       (arst_n),
        .word_req     (word_req),
        .word_addr    (word_addr),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .word_valid   (word_valid),
        .word_data    (word_data)
    );

endmodule

//--- cpu_port.sv
`include "cache_defines.svh"

module cpu_port (
    input  logic                   clk,
    input  logic                   arst_n,
    input  cache_pkg::wb_req_t     cpu_req,
    output cache_pkg::wb_rsp_t     cpu_rsp,
    output logic                   lookup_valid,
    output cache_pkg::cache_addr_u lookup_addr,
    input  logic                   hit,
    input  logic [`DATA_W-1:0]     rd_data,
    output logic                   miss,
    output cache_pkg::cache_addr_u fill_addr_in,
    input  logic                   fill_busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_REFILL
    } state_t;

    state_t                 state_q;
    logic                   ack_q;
    logic                   miss_q;
    logic                   lookup_valid_q;
    logic [`DATA_W-1:0]     dat_q;
    cache_pkg::cache_addr_u addr_q;
    logic                   req_take;
    logic                   result_rdy;

    // ack_q blocks the sample in the ack cycle, master still holds stb there
    assign req_take = (state_q == ST_IDLE) && cpu_req.cyc && cpu_req.stb && !ack_q;

    // second lookup cycle, store has registered hit and rd_data
    assign result_rdy = (state_q == ST_LOOKUP) && !lookup_valid_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q        <= ST_IDLE;
            ack_q          <= 1'b0;
            miss_q         <= 1'b0;
            lookup_valid_q <= 1'b0;
        end else begin
            // pulses by default
            ack_q          <= 1'b0;
            miss_q         <= 1'b0;
            lookup_valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (req_take) begin
                        lookup_valid_q <= 1'b1;
                        state_q        <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (result_rdy) begin
                        if (hit) begin
                            ack_q   <= 1'b1;
                            state_q <= ST_IDLE;
                        end else begin
                            miss_q  <= 1'b1;
                            state_q <= ST_REFILL;
                        end
                    end
                end
                ST_REFILL: begin
                    // miss_q still high in the first cycle, fill_busy not up yet
                    if (!miss_q && !fill_busy) begin
                        lookup_valid_q <= 1'b1;
                        state_q        <= ST_LOOKUP;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // request address and returned word
    always_ff @(posedge clk) begin
        if (req_take) begin
            addr_q <= cpu_req.adr;
        end
        if (result_rdy && hit) begin
            dat_q <= rd_data;
        end
    end

    assign cpu_rsp.ack  = ack_q;
    assign cpu_rsp.dat  = dat_q;
    assign lookup_valid = lookup_valid_q;
    assign lookup_addr  = addr_q;
    assign miss         = miss_q;
    // the fill fetches the line of the address that just missed
    assign fill_addr_in = addr_q;

endmodule

//--- mem_port.sv
`include "cache_defines.svh"

module mem_port (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   word_req,
    input  cache_pkg::cache_addr_u word_addr,
    output cache_pkg::wb_req_t     mem_req,
    input  cache_pkg::wb_rsp_t     mem_rsp,
    output logic                   word_valid,
    output logic [`DATA_W-1:0]     word_data
);

    logic                   cyc_q;
    logic                   word_valid_q;
    cache_pkg::cache_addr_u adr_q;
    logic [`DATA_W-1:0]     data_q;
    logic                   bus_done;

    // transfer ends on the cycle ack is seen
    assign bus_done = cyc_q && mem_rsp.ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc_q        <= 1'b0;
            word_valid_q <= 1'b0;
        end else begin
            word_valid_q <= bus_done;
            if (bus_done) begin
                cyc_q <= 1'b0;
            end else if (word_req) begin
                // fill only asks again after word_valid, so the bus is free
                cyc_q <= 1'b1;
            end
        end
    end

    // address held stable for the whole cycle
    // returned word kept for the word_valid cycle
    always_ff @(posedge clk) begin
        if (word_req && !cyc_q) begin
            adr_q <= word_addr;
        end
        if (bus_done) begin
            data_q <= mem_rsp.dat;
        end
    end

    // classic single read, stb follows cyc
    assign mem_req.cyc = cyc_q;
    assign mem_req.stb = cyc_q;
    assign mem_req.adr = adr_q;

    assign word_valid = word_valid_q;
    assign word_data  = data_q;

endmodule

//--- tb_cache.sv
`include "cache_defines.svh"

module tb_cache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 200;

    logic                   clk;
    logic                   arst_n;
    cache_pkg::wb_req_t     cpu_req;
    cache_pkg::wb_rsp_t     cpu_rsp;
    cache_pkg::wb_req_t     mem_req;
    cache_pkg::wb_rsp_t     mem_rsp;

    // separate streams so stimulus and memory waits do not interleave
    logic [15:0]            stim_lfsr = 16'd71;
    logic [15:0]            mem_lfsr = 16'd71;

    // lines a direct mapped cache of this geometry should hold
    logic [`TAG_W-1:0]      ref_tag [`LINES];
    logic                   ref_valid [`LINES];

    // one entry per outstanding request and popped on ack
    logic [`DATA_W-1:0]     exp_data_q [$];
    int                     exp_fill_q [$];
    cache_pkg::cache_addr_u exp_addr_q [$];
    cache_pkg::cache_addr_u mem_log [$];
    logic                   cyc_seen = 1'b0;
    logic                   mem_busy = 1'b0;
    int                     mem_wait = 0;
    logic [15:0]            rnd_adr;

    tb_clk_gen u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    cache_top UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    // galois lfsr stepped once per bit taken
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [15:0] stim_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], stim_lfsr[0]};
            stim_lfsr = lfsr_step(stim_lfsr);
        end
        return v;
    endfunction

    // 0 to 3 wait states
    function automatic int pick_mem_wait();
        int v;
        v = 0;
        for (int i = 0; i < 2; i++) begin
            v = (v << 1) | mem_lfsr[0];
            mem_lfsr = lfsr_step(mem_lfsr);
        end
        return v;
    endfunction

    // memory contents are the address rotated left by 5 then xored
    function automatic logic [15:0] mem_word(input logic [15:0] adr);
        return {adr[10:0], adr[15:11]} ^ 16'h5A3C;
    endfunction

    // returns the expected word and fill read count and updates the line tracking
    function automatic logic [15:0] expected_word(input logic [15:0] adr, output int fills);
        logic [7:0] tag;
        logic [3:0] idx;
        tag = adr[15:8];
        idx = adr[7:4];
        if (ref_valid[idx] && ref_tag[idx] == tag) begin
            fills = 0;
        end else begin
            fills = 8;
            ref_valid[idx] = 1'b1;
            ref_tag[idx] = tag;
        end
        return mem_word({adr[15:1], 1'b0});
    endfunction

    task automatic report_mismatch(input string msg);
        $display("** Error @ %0t ns: %s", $time, msg);
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_rsp(input cache_pkg::wb_rsp_t got, input logic [`DATA_W-1:0] exp,
                             input cache_pkg::cache_addr_u adr);
        if (got.dat !== exp) begin
            report_mismatch($sformatf("read %h returned %h, expected %h", adr.raw, got.dat, exp));
        end
    endtask

    task automatic check_mem_adr(input cache_pkg::cache_addr_u got,
                                 input cache_pkg::cache_addr_u exp);
        if (got.raw !== exp.raw) begin
            report_mismatch($sformatf("fill read at %h, expected %h", got.raw, exp.raw));
        end
    endtask

    task automatic check_fill_count(input int got, input int exp);
        if (got != exp) begin
            report_mismatch($sformatf("%0d memory reads for one request, expected %0d", got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            report_mismatch($sformatf("hit acked after %0d cycles, expected %0d", got, exp));
        end
    endtask

    // one processor read held until ack
    task automatic read_word(input logic [15:0] adr);
        logic [15:0] exp;
        int          fills;
        int          cycles;
        logic        got_ack;
        @(posedge clk);
        #1;
        exp = expected_word(adr, fills);
        exp_data_q.push_back(exp);
        exp_fill_q.push_back(fills);
        exp_addr_q.push_back(adr);
        cpu_req.cyc = 1'b1;
        cpu_req.stb = 1'b1;
        cpu_req.adr = adr;
        cycles = 0;
        got_ack = 1'b0;
        while (!got_ack) begin
            @(negedge clk);
            cycles++;
            if (cpu_rsp.ack) begin
                got_ack = 1'b1;
            end else if (cycles >= WAIT_LIMIT) begin
                abort_run($sformatf("timeout waiting for the ack of read %h", adr));
            end
        end
        // one negedge falls before the sample edge
        // and an ack raised on edge n after it is seen on negedge n + 1
        if (fills == 0) begin
            check_latency(cycles - 2, 2);
        end
        // drop stb in the cycle after ack
        @(posedge clk);
        #1;
        cpu_req.cyc = 1'b0;
        cpu_req.stb = 1'b0;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (!arst_n) begin
            @(negedge clk);
            cycles++;
            if (cycles >= WAIT_LIMIT) begin
                abort_run("timeout waiting for reset release");
            end
        end
    endtask

    // memory model answering after 0 to 3 wait states
    initial begin
        mem_rsp = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_rsp.ack) begin
                mem_rsp.ack = 1'b0;
            end else if (arst_n && mem_req.cyc && mem_req.stb) begin
                if (!mem_busy) begin
                    mem_busy = 1'b1;
                    mem_wait = pick_mem_wait();
                end
                if (mem_wait == 0) begin
                    mem_rsp.ack = 1'b1;
                    mem_rsp.dat = mem_word(mem_req.adr.raw);
                    mem_busy = 1'b0;
                end else begin
                    mem_wait--;
                end
            end
        end
    end

    // logs each memory transfer and catches cycles outside a fill
    always @(negedge clk) begin
        if (arst_n) begin
            if (mem_req.cyc !== mem_req.stb) begin
                abort_run("memory side cyc and stb differ");
            end
            if (mem_req.cyc && !cyc_seen) begin
                if (exp_fill_q.size() == 0 || exp_fill_q[0] == 0) begin
                    abort_run("memory cycle started while no fill was pending");
                end
                $display("%0t ns memory read at %h", $time, mem_req.adr.raw);
                mem_log.push_back(mem_req.adr);
            end
            cyc_seen = mem_req.cyc;
        end
    end

    // compares every ack with the oldest expected result
    always @(negedge clk) begin
        cache_pkg::cache_addr_u adr;
        cache_pkg::cache_addr_u line_adr;
        logic [`DATA_W-1:0]     exp;
        int                     fills;
        if (arst_n && cpu_rsp.ack) begin
            if (exp_data_q.size() == 0) begin
                abort_run("processor ack with no request outstanding");
            end
            exp = exp_data_q.pop_front();
            fills = exp_fill_q.pop_front();
            adr = exp_addr_q.pop_front();
            check_rsp(cpu_rsp, exp, adr);
            check_fill_count(mem_log.size(), fills);
            // whole line in order from word 0
            for (int i = 0; i < fills; i++) begin
                line_adr.raw = (adr.raw & 16'hFFF0) + 16'(2 * i);
                check_mem_adr(mem_log[i], line_adr);
            end
            mem_log.delete();
        end
    end

    initial begin
        cpu_req = '0;
        for (int i = 0; i < `LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_tag[i] = '0;
        end
        wait_reset_release();
        // quiet bus after reset
        repeat (5) begin
            @(negedge clk);
            if (cpu_rsp.ack || mem_req.cyc) begin
                report_mismatch("ack or memory cycle raised while idle after reset");
            end
        end
        // cold miss then the rest of the line hits
        read_word(16'h1236);
        for (int w = 0; w < 8; w++) begin
            if (w != 3) begin
                read_word(16'h1230 + 16'(2 * w));
            end
        end
        // tags 56 and 12 share index 3 and evict each other
        for (int i = 0; i < 6; i++) begin
            read_word((i % 2 == 0) ? 16'h5634 : 16'h123A);
        end
        // random reads over four tags with random gaps
        for (int n = 0; n < 200; n++) begin
            repeat (stim_bits(2)) @(posedge clk);
            rnd_adr = 16'h1000 | stim_bits(10);
            read_word(rnd_adr);
        end
        repeat (20) @(posedge clk);
        if (exp_data_q.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run("run ended with a read still waiting for its ack");
        end
    end

endmodule

//--- tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset low for 10 cycles, released just after an edge
    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

//--- vlog.f
+incdir+.
cache_pkg.sv
cpu_port.sv
cache_store.sv
cache_fill_fsm.sv
mem_port.sv
cache_top.sv
tb_clk_gen.sv
tb_cache.sv
